//--- logic/cpu_cfg_pkg.sv
package cpu_cfg_pkg;

	// Width of a data word and of an address
	localparam int XLEN = 32;

	// Register numbers select one of 32 general registers
	localparam int REG_ADDR_W = 5;

	// Shift amounts cover every bit position of a word
	localparam int SHAMT_W = 5;

	// Iterations of the multiply and divide loops, one per operand bit
	localparam int MD_STEPS = 32;

endpackage

//--- logic/ex_ctrl_pkg.sv
package ex_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		ALU_SLT  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_LUI  = 4'd8
	} alu_op_e;

	typedef enum logic [1:0] {
		SH_SLL = 2'd0,
		SH_SRL = 2'd1,
		SH_SRA = 2'd2
	} shift_op_e;

	// MDU_NONE must stay zero so a flushed slot carries no operation
	typedef enum logic [3:0] {
		MDU_NONE  = 4'd0,
		MDU_MULT  = 4'd1,
		MDU_MULTU = 4'd2,
		MDU_DIV   = 4'd3,
		MDU_DIVU  = 4'd4,
		MDU_MTHI  = 4'd5,
		MDU_MTLO  = 4'd6
	} mdu_op_e;

	typedef enum logic [2:0] {
		RES_ALU   = 3'd0,
		RES_SHIFT = 3'd1,
		RES_HI    = 3'd2,
		RES_LO    = 3'd3,
		RES_LINK  = 3'd4, // Return address from decode
		RES_CP0   = 3'd5
	} result_sel_e;

endpackage

//--- logic/id_ex_register.sv
module id_ex_register (
	input  logic                               clk,
	input  logic                               rst_n_i,
	input  logic                               hold_i,
	input  logic                               flush_i,
	input  logic                               id_regwr_i,
	input  logic                               id_memtoreg_i,
	input  logic                               id_memwr_i,
	input  logic                               id_dmen_i,
	input  logic [3:0]                         id_bytesel_i,
	input  logic                               id_extsigned_i,
	input  ex_ctrl_pkg::result_sel_e           id_result_sel_i,
	input  logic                               id_alu_b_sel_i,
	input  ex_ctrl_pkg::alu_op_e               id_alu_op_i,
	input  ex_ctrl_pkg::mdu_op_e               id_mdu_op_i,
	input  ex_ctrl_pkg::shift_op_e             id_shift_op_i,
	input  logic                               id_of_ctrl_i,
	input  logic [cpu_cfg_pkg::SHAMT_W-1:0]    id_shamt_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_a_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_b_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_imm_i,
	input  logic [cpu_cfg_pkg::REG_ADDR_W-1:0] id_regdst_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_cp0_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_link_addr_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_pc_i,
	output logic                               ex_regwr_o,
	output logic                               ex_memtoreg_o,
	output logic                               ex_memwr_o,
	output logic                               ex_dmen_o,
	output logic [3:0]                         ex_bytesel_o,
	output logic                               ex_extsigned_o,
	output ex_ctrl_pkg::result_sel_e           ex_result_sel_o,
	output logic                               ex_alu_b_sel_o,
	output ex_ctrl_pkg::alu_op_e               ex_alu_op_o,
	output ex_ctrl_pkg::mdu_op_e               ex_mdu_op_o,
	output ex_ctrl_pkg::shift_op_e             ex_shift_op_o,
	output logic                               ex_of_ctrl_o,
	output logic [cpu_cfg_pkg::SHAMT_W-1:0]    ex_shamt_o,
	output logic [cpu_cfg_pkg::XLEN-1:0]       ex_a_o,
	output logic [cpu_cfg_pkg::XLEN-1:0]       ex_b_o,
	output logic [cpu_cfg_pkg::XLEN-1:0]       ex_imm_o,
	output logic [cpu_cfg_pkg::REG_ADDR_W-1:0] ex_regdst_o,
	output logic [cpu_cfg_pkg::XLEN-1:0]       ex_cp0_o,
	output logic [cpu_cfg_pkg::XLEN-1:0]       ex_link_addr_o,
	output logic [cpu_cfg_pkg::XLEN-1:0]       ex_pc_o
);
	import ex_ctrl_pkg::*;

	// A flush wins over hold and leaves a bubble in EX
	always_ff @(posedge clk) begin
		if (!rst_n_i || flush_i) begin
			ex_regwr_o      <= 1'b0;
			ex_memtoreg_o   <= 1'b0;
			ex_memwr_o      <= 1'b0;
			ex_dmen_o       <= 1'b0;
			ex_bytesel_o    <= '0;
			ex_extsigned_o  <= 1'b0;
			ex_result_sel_o <= RES_ALU;
			ex_alu_b_sel_o  <= 1'b0;
			ex_alu_op_o     <= ALU_ADD;
			ex_mdu_op_o     <= MDU_NONE;
			ex_shift_op_o   <= SH_SLL;
			ex_of_ctrl_o    <= 1'b0;
			ex_shamt_o      <= '0;
			ex_a_o          <= '0;
			ex_b_o          <= '0;
			ex_imm_o        <= '0;
			ex_regdst_o     <= '0;
			ex_cp0_o        <= '0;
			ex_link_addr_o  <= '0;
			ex_pc_o         <= '0;
		end else if (!hold_i) begin
			ex_regwr_o      <= id_regwr_i;
			ex_memtoreg_o   <= id_memtoreg_i;
			ex_memwr_o      <= id_memwr_i;
			ex_dmen_o       <= id_dmen_i;
			ex_bytesel_o    <= id_bytesel_i;
			ex_extsigned_o  <= id_extsigned_i;
			ex_result_sel_o <= id_result_sel_i;
			ex_alu_b_sel_o  <= id_alu_b_sel_i;
			ex_alu_op_o     <= id_alu_op_i;
			ex_mdu_op_o     <= id_mdu_op_i;
			ex_shift_op_o   <= id_shift_op_i;
			ex_of_ctrl_o    <= id_of_ctrl_i;
			ex_shamt_o      <= id_shamt_i;
			ex_a_o          <= id_a_i;
			ex_b_o          <= id_b_i;
			ex_imm_o        <= id_imm_i;
			ex_regdst_o     <= id_regdst_i;
			ex_cp0_o        <= id_cp0_i;
			ex_link_addr_o  <= id_link_addr_i;
			ex_pc_o         <= id_pc_i;
		end
	end

	// A flushed slot must never write state, even when hold is also high
	assert property (@(posedge clk) disable iff (!rst_n_i)
		flush_i |=> !ex_regwr_o && !ex_memwr_o && !ex_dmen_o && ex_mdu_op_o == MDU_NONE);

endmodule

//--- logic/ex_alu.sv
module ex_alu (
	input  logic [cpu_cfg_pkg::XLEN-1:0] a_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0] b_i,
	input  ex_ctrl_pkg::alu_op_e         op_i,
	output logic [cpu_cfg_pkg::XLEN-1:0] result_o,
	output logic                         ovf_o
);
	import cpu_cfg_pkg::*;
	import ex_ctrl_pkg::*;

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;
	logic            lt_signed;
	logic            lt_unsigned;

	assign sum         = a_i + b_i;
	assign diff        = a_i - b_i;
	assign lt_signed   = $signed(a_i) < $signed(b_i);
	assign lt_unsigned = a_i < b_i;

	always_comb begin
		result_o = '0;
		ovf_o    = 1'b0;
		case (op_i)
			ALU_ADD: begin
				result_o = sum;
				// Operands of equal sign that give a result of the other sign
				ovf_o = (a_i[XLEN-1] == b_i[XLEN-1]) && (sum[XLEN-1] != a_i[XLEN-1]);
			end
			ALU_SUB: begin
				result_o = diff;
				ovf_o = (a_i[XLEN-1] != b_i[XLEN-1]) && (diff[XLEN-1] != a_i[XLEN-1]);
			end
			ALU_AND: begin
				result_o = a_i & b_i;
			end
			ALU_OR: begin
				result_o = a_i | b_i;
			end
			ALU_XOR: begin
				result_o = a_i ^ b_i;
			end
			ALU_NOR: begin
				result_o = ~(a_i | b_i);
			end
			ALU_SLT: begin
				result_o = {{(XLEN-1){1'b0}}, lt_signed};
			end
			ALU_SLTU: begin
				result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			end
			ALU_LUI: begin
				result_o = {b_i[XLEN/2-1:0], {(XLEN/2){1'b0}}}; // Immediate arrives on B
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

//--- logic/ex_shifter.sv
module ex_shifter (
	input  logic [cpu_cfg_pkg::XLEN-1:0]    value_i,
	input  logic [cpu_cfg_pkg::SHAMT_W-1:0] shamt_i,
	input  ex_ctrl_pkg::shift_op_e          op_i,
	output logic [cpu_cfg_pkg::XLEN-1:0]    result_o
);
	import cpu_cfg_pkg::*;
	import ex_ctrl_pkg::*;

	logic            fill;
	logic [XLEN-1:0] src;
	logic [XLEN-1:0] stage;

	// Left shifts go through the same right shifter on the bit-reversed word
	always_comb begin
		fill = (op_i == SH_SRA) && value_i[XLEN-1];
		for (int i = 0; i < XLEN; i++) begin
			src[i] = (op_i == SH_SLL) ? value_i[XLEN-1-i] : value_i[i];
		end
		stage = src;
		for (int s = 0; s < SHAMT_W; s++) begin
			if (shamt_i[s]) begin // Stage s moves the word by 2**s places
				stage = (stage >> (1 << s)) | ({XLEN{fill}} & ~({XLEN{1'b1}} >> (1 << s)));
			end
		end
		for (int i = 0; i < XLEN; i++) begin
			result_o[i] = (op_i == SH_SLL) ? stage[XLEN-1-i] : stage[i];
		end
	end

endmodule

//--- logic/ex_muldiv.sv
module ex_muldiv (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  logic                         start_i,
	input  ex_ctrl_pkg::mdu_op_e         op_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0] a_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0] b_i,
	output logic                         busy_o,
	output logic [cpu_cfg_pkg::XLEN-1:0] hi_o,
	output logic [cpu_cfg_pkg::XLEN-1:0] lo_o
);
	import cpu_cfg_pkg::*;
	import ex_ctrl_pkg::*;

	typedef enum logic [1:0] {
		MD_IDLE,
		MD_MUL,
		MD_DIV
	} md_state_e;

	md_state_e                   state;
	logic [$clog2(MD_STEPS)-1:0] count;
	logic [2*XLEN-1:0]           acc;    // Product, or remainder over quotient
	logic [XLEN-1:0]             opnd;   // Multiplicand or divisor magnitude
	logic                        neg_lo; // Product or quotient takes a minus sign
	logic                        neg_hi; // Remainder follows the dividend sign
	logic                        is_signed;
	logic [XLEN-1:0]             a_abs;
	logic [XLEN-1:0]             b_abs;
	logic [XLEN:0]               mul_sum;
	logic [XLEN:0]               div_try;
	logic [XLEN:0]               div_diff;
	logic [2*XLEN-1:0]           acc_next;
	logic [2*XLEN-1:0]           prod_fix;
	logic [XLEN-1:0]             quo_fix;
	logic [XLEN-1:0]             rem_fix;

	assign is_signed = (op_i == MDU_MULT) || (op_i == MDU_DIV);
	assign a_abs     = (is_signed && a_i[XLEN-1]) ? -a_i : a_i;
	assign b_abs     = (is_signed && b_i[XLEN-1]) ? -b_i : b_i;
	assign busy_o    = state != MD_IDLE;

	// One shift-add or one restoring subtract per cycle
	always_comb begin
		mul_sum  = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, opnd} : '0);
		div_try  = acc[2*XLEN-1:XLEN-1];
		div_diff = div_try - {1'b0, opnd};
		if (state == MD_MUL) begin
			acc_next = {mul_sum, acc[XLEN-1:1]};
		end else if (!div_diff[XLEN]) begin
			acc_next = {div_diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};
		end else begin
			acc_next = {div_try[XLEN-1:0], acc[XLEN-2:0], 1'b0};
		end
		prod_fix = neg_lo ? -acc_next : acc_next;
		quo_fix  = neg_lo ? -acc_next[XLEN-1:0] : acc_next[XLEN-1:0];
		rem_fix  = neg_hi ? -acc_next[2*XLEN-1:XLEN] : acc_next[2*XLEN-1:XLEN];
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state <= MD_IDLE;
			hi_o  <= '0;
			lo_o  <= '0;
		end else begin
			case (state)
				MD_IDLE: begin
					if (start_i) begin
						case (op_i)
							MDU_MULT, MDU_MULTU: state <= MD_MUL;
							MDU_DIV, MDU_DIVU:   state <= MD_DIV;
							MDU_MTHI:            hi_o  <= a_i;
							MDU_MTLO:            lo_o  <= a_i;
							default:             state <= MD_IDLE;
						endcase
					end
				end
				MD_MUL: begin
					if (count == '0) begin // Result lands with the last step
						state        <= MD_IDLE;
						{hi_o, lo_o} <= prod_fix;
					end
				end
				MD_DIV: begin
					if (count == '0) begin
						state <= MD_IDLE;
						hi_o  <= rem_fix;
						lo_o  <= quo_fix;
					end
				end
				default: state <= MD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == MD_IDLE) begin
			acc    <= {{XLEN{1'b0}}, a_abs};
			opnd   <= b_abs;
			count  <= ($clog2(MD_STEPS))'(MD_STEPS - 1);
			neg_lo <= is_signed && (a_i[XLEN-1] ^ b_i[XLEN-1]);
			neg_hi <= is_signed && a_i[XLEN-1];
		end else begin
			acc   <= acc_next;
			count <= count - 1'b1;
		end
	end

	// The stage must wait for the unit to drain before it issues again
	assert property (@(posedge clk) disable iff (!rst_n_i) busy_o |-> !start_i);

endmodule

//--- logic/execute_unit.sv
module execute_unit (
	input  logic                               clk,
	input  logic                               rst_n_i,
	input  logic                               hold_i,
	input  logic                               flush_i,
	input  logic                               id_regwr_i,
	input  logic                               id_memtoreg_i,
	input  logic                               id_memwr_i,
	input  logic                               id_dmen_i,
	input  logic [3:0]                         id_bytesel_i,
	input  logic                               id_extsigned_i,
	input  ex_ctrl_pkg::result_sel_e           id_result_sel_i,
	input  logic                               id_alu_b_sel_i,
	input  ex_ctrl_pkg::alu_op_e               id_alu_op_i,
	input  ex_ctrl_pkg::mdu_op_e               id_mdu_op_i,
	input  ex_ctrl_pkg::shift_op_e             id_shift_op_i,
	input  logic                               id_of_ctrl_i,
	input  logic [cpu_cfg_pkg::SHAMT_W-1:0]    id_shamt_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_a_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_b_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_imm_i,
	input  logic [cpu_cfg_pkg::REG_ADDR_W-1:0] id_regdst_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_cp0_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_link_addr_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]       id_pc_i,
	output logic                               stall_o,
	output logic                               exc_ov_o,
	output logic                               mem_regwr_o,
	output logic                               mem_memtoreg_o,
	output logic                               mem_memwr_o,
	output logic                               mem_dmen_o,
	output logic [3:0]                         mem_bytesel_o,
	output logic                               mem_extsigned_o,
	output logic [cpu_cfg_pkg::XLEN-1:0]       mem_result_o,
	output logic [cpu_cfg_pkg::XLEN-1:0]       mem_store_data_o,
	output logic [cpu_cfg_pkg::REG_ADDR_W-1:0] mem_regdst_o,
	output logic [cpu_cfg_pkg::XLEN-1:0]       mem_pc_o
);
	import cpu_cfg_pkg::*;
	import ex_ctrl_pkg::*;

	logic                  ex_regwr;
	logic                  ex_memtoreg;
	logic                  ex_memwr;
	logic                  ex_dmen;
	logic [3:0]            ex_bytesel;
	logic                  ex_extsigned;
	result_sel_e           ex_result_sel;
	logic                  ex_alu_b_sel;
	alu_op_e               ex_alu_op;
	mdu_op_e               ex_mdu_op;
	shift_op_e             ex_shift_op;
	logic                  ex_of_ctrl;
	logic [SHAMT_W-1:0]    ex_shamt;
	logic [XLEN-1:0]       ex_a;
	logic [XLEN-1:0]       ex_b;
	logic [XLEN-1:0]       ex_imm;
	logic [REG_ADDR_W-1:0] ex_regdst;
	logic [XLEN-1:0]       ex_cp0;
	logic [XLEN-1:0]       ex_link_addr;
	logic [XLEN-1:0]       ex_pc;
	logic [XLEN-1:0]       alu_b;
	logic [XLEN-1:0]       alu_result;
	logic                  alu_ovf;
	logic [SHAMT_W-1:0]    shamt;
	logic [XLEN-1:0]       shift_result;
	logic                  md_start;
	logic                  md_busy;
	logic [XLEN-1:0]       hi;
	logic [XLEN-1:0]       lo;
	logic [XLEN-1:0]       ex_result;
	logic                  id_ex_hold;
	logic                  ov_cancel;

	id_ex_register id_ex_register_i (
		.clk, .rst_n_i, .hold_i(id_ex_hold), .flush_i,
		.id_regwr_i, .id_memtoreg_i, .id_memwr_i, .id_dmen_i, .id_bytesel_i,
		.id_extsigned_i, .id_result_sel_i, .id_alu_b_sel_i, .id_alu_op_i,
		.id_mdu_op_i, .id_shift_op_i, .id_of_ctrl_i, .id_shamt_i, .id_a_i,
		.id_b_i, .id_imm_i, .id_regdst_i, .id_cp0_i, .id_link_addr_i, .id_pc_i,
		.ex_regwr_o(ex_regwr), .ex_memtoreg_o(ex_memtoreg), .ex_memwr_o(ex_memwr),
		.ex_dmen_o(ex_dmen), .ex_bytesel_o(ex_bytesel), .ex_extsigned_o(ex_extsigned),
		.ex_result_sel_o(ex_result_sel), .ex_alu_b_sel_o(ex_alu_b_sel),
		.ex_alu_op_o(ex_alu_op), .ex_mdu_op_o(ex_mdu_op), .ex_shift_op_o(ex_shift_op),
		.ex_of_ctrl_o(ex_of_ctrl), .ex_shamt_o(ex_shamt), .ex_a_o(ex_a), .ex_b_o(ex_b),
		.ex_imm_o(ex_imm), .ex_regdst_o(ex_regdst), .ex_cp0_o(ex_cp0),
		.ex_link_addr_o(ex_link_addr), .ex_pc_o(ex_pc)
	);

	assign alu_b = ex_alu_b_sel ? ex_imm : ex_b;
	assign shamt = ex_alu_b_sel ? ex_shamt : ex_a[SHAMT_W-1:0]; // Immediate form uses the shamt field

	ex_alu ex_alu_i (.a_i(ex_a), .b_i(alu_b), .op_i(ex_alu_op), .result_o(alu_result),
		.ovf_o(alu_ovf));

	ex_shifter ex_shifter_i (.value_i(ex_b), .shamt_i(shamt), .op_i(ex_shift_op),
		.result_o(shift_result));

	// A multiply or divide leaves EX on the same edge that starts it
	assign md_start = (ex_mdu_op != MDU_NONE) && !md_busy && !hold_i;

	ex_muldiv ex_muldiv_i (.clk, .rst_n_i, .start_i(md_start), .op_i(ex_mdu_op), .a_i(ex_a),
		.b_i(ex_b), .busy_o(md_busy), .hi_o(hi), .lo_o(lo));

	assign stall_o = md_busy && (ex_result_sel == RES_HI || ex_result_sel == RES_LO ||
		ex_mdu_op != MDU_NONE);
	assign id_ex_hold = hold_i || stall_o;
	assign ov_cancel  = ex_of_ctrl && alu_ovf;

	always_comb begin
		case (ex_result_sel)
			RES_SHIFT: ex_result = shift_result;
			RES_HI:    ex_result = hi;
			RES_LO:    ex_result = lo;
			RES_LINK:  ex_result = ex_link_addr;
			RES_CP0:   ex_result = ex_cp0;
			default:   ex_result = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			mem_regwr_o     <= 1'b0;
			mem_memtoreg_o  <= 1'b0;
			mem_memwr_o     <= 1'b0;
			mem_dmen_o      <= 1'b0;
			mem_bytesel_o   <= '0;
			mem_extsigned_o <= 1'b0;
			exc_ov_o        <= 1'b0;
		end else if (!hold_i) begin
			if (stall_o) begin // Bubble while the EX instruction waits
				mem_regwr_o    <= 1'b0;
				mem_memtoreg_o <= 1'b0;
				mem_memwr_o    <= 1'b0;
				mem_dmen_o     <= 1'b0;
				exc_ov_o       <= 1'b0;
			end else begin
				mem_regwr_o    <= ex_regwr && !ov_cancel;
				mem_memtoreg_o <= ex_memtoreg && !ov_cancel;
				mem_memwr_o    <= ex_memwr && !ov_cancel;
				mem_dmen_o     <= ex_dmen && !ov_cancel;
				exc_ov_o       <= ov_cancel;
			end
			mem_bytesel_o   <= ex_bytesel;
			mem_extsigned_o <= ex_extsigned;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold_i) begin
			mem_result_o     <= ex_result;
			mem_store_data_o <= ex_b;
			mem_regdst_o     <= ex_regdst;
			mem_pc_o         <= ex_pc; // Exception handler reads the faulting pc here
		end
	end

	// A started multiply or divide must keep later HI and LO readers waiting
	assert property (@(posedge clk) disable iff (!rst_n_i)
		md_start && (ex_mdu_op == MDU_MULT || ex_mdu_op == MDU_MULTU ||
		ex_mdu_op == MDU_DIV || ex_mdu_op == MDU_DIVU) |=> md_busy);

endmodule

//--- bench/execute_unit_tb.sv
module execute_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import cpu_cfg_pkg::*;
	import ex_ctrl_pkg::*;

	localparam int N_INSTR     = 400;
	localparam int ISSUE_LIMIT = 40000;
	localparam int DRAIN_LIMIT = 200;

	typedef struct packed {
		logic        regwr;
		logic        memtoreg;
		logic        memwr;
		logic        dmen;
		logic [3:0]  bytesel;
		logic        extsigned;
		result_sel_e result_sel;
		logic        alu_b_sel;
		alu_op_e     alu_op;
		mdu_op_e     mdu_op;
		shift_op_e   shift_op;
		logic        of_ctrl;
		logic [4:0]  shamt;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [4:0]  regdst;
		logic [31:0] cp0;
		logic [31:0] link;
		logic [31:0] pc;
	} instr_t;

	// One expected EX/MEM entry
	typedef struct packed {
		logic        regwr;
		logic        memtoreg;
		logic        memwr;
		logic        dmen;
		logic        exc;
		logic [3:0]  bytesel;
		logic        extsigned;
		logic [31:0] result;
		logic [31:0] store;
		logic [4:0]  regdst;
		logic [31:0] pc;
	} entry_t;

	logic        clk;
	logic        rst_n_i;
	logic        hold_i;
	logic        flush_i;
	instr_t      cur;
	logic        cur_valid;
	logic        stall_o;
	logic        exc_ov_o;
	logic        mem_regwr_o;
	logic        mem_memtoreg_o;
	logic        mem_memwr_o;
	logic        mem_dmen_o;
	logic [3:0]  mem_bytesel_o;
	logic        mem_extsigned_o;
	logic [31:0] mem_result_o;
	logic [31:0] mem_store_data_o;
	logic [4:0]  mem_regdst_o;
	logic [31:0] mem_pc_o;

	integer      seed;
	int          errors;
	int          issued;
	int          busy_left;
	logic [31:0] pc_next;
	logic [31:0] hi_m;
	logic [31:0] lo_m;
	instr_t      ex_m; // Model copy of ID/EX
	logic        ex_valid;
	logic        mem_loaded; // EX/MEM took a new entry at the last edge
	entry_t      expq[$];

	execute_unit execute_unit_i (
		.clk, .rst_n_i, .hold_i, .flush_i,
		.id_regwr_i(cur.regwr), .id_memtoreg_i(cur.memtoreg), .id_memwr_i(cur.memwr),
		.id_dmen_i(cur.dmen), .id_bytesel_i(cur.bytesel), .id_extsigned_i(cur.extsigned),
		.id_result_sel_i(cur.result_sel), .id_alu_b_sel_i(cur.alu_b_sel),
		.id_alu_op_i(cur.alu_op), .id_mdu_op_i(cur.mdu_op), .id_shift_op_i(cur.shift_op),
		.id_of_ctrl_i(cur.of_ctrl), .id_shamt_i(cur.shamt), .id_a_i(cur.a), .id_b_i(cur.b),
		.id_imm_i(cur.imm), .id_regdst_i(cur.regdst), .id_cp0_i(cur.cp0),
		.id_link_addr_i(cur.link), .id_pc_i(cur.pc),
		.stall_o, .exc_ov_o, .mem_regwr_o, .mem_memtoreg_o, .mem_memwr_o, .mem_dmen_o,
		.mem_bytesel_o, .mem_extsigned_o, .mem_result_o, .mem_store_data_o, .mem_regdst_o,
		.mem_pc_o
	);

	always #5 clk = ~clk;

	// Corner values now and then so overflow and divide by zero come up
	function automatic logic [31:0] pick_operand();
		logic [31:0] r;
		r = $random(seed);
		if (r[2:0] != 3'd0)
			return $random(seed);
		case (r[4:3])
			2'd0: return 32'h0000_0000;
			2'd1: return 32'h7fff_ffff;
			2'd2: return 32'h8000_0000;
			default: return 32'hffff_ffff;
		endcase
	endfunction

	function automatic instr_t gen_instr();
		instr_t      t;
		logic [31:0] r;
		int          kind;
		t = '0;
		kind = $random(seed) & 15;
		t.pc = pc_next;
		pc_next = pc_next + 32'd4;
		t.a = pick_operand();
		t.b = pick_operand();
		t.imm = $random(seed);
		t.cp0 = $random(seed);
		t.link = $random(seed);
		r = $random(seed);
		t.dmen = r[0];
		t.memwr = r[0] & r[1];
		t.memtoreg = r[0] & ~r[1] & r[2];
		t.regwr = r[3] | ~r[0]; // Never a bubble
		t.bytesel = r[7:4];
		t.extsigned = r[8];
		t.regdst = r[13:9];
		t.shamt = r[18:14];
		t.alu_b_sel = r[19];
		r = $random(seed);
		case (kind)
			0, 1, 2, 3, 4, 5, 6: begin
				t.alu_op = alu_op_e'(4'(r[7:0] % 9));
				t.of_ctrl = r[8];
			end
			7, 8: begin
				t.result_sel = RES_SHIFT;
				t.shift_op = shift_op_e'(2'(r[7:0] % 3));
			end
			9: begin
				t.mdu_op = mdu_op_e'(4'(1 + r[7:0] % 4));
				if (r[10:8] == 3'd0)
					t.b = '0;
			end
			10: t.mdu_op = r[8] ? MDU_MTHI : MDU_MTLO;
			11, 12: t.result_sel = r[8] ? RES_HI : RES_LO;
			13: t.result_sel = RES_LINK;
			14: t.result_sel = RES_CP0;
			default: begin
				t.alu_op = r[8] ? ALU_SUB : ALU_ADD;
				t.of_ctrl = 1'b1;
				t.alu_b_sel = 1'b0;
			end
		endcase
		return t;
	endfunction

	function automatic logic [31:0] alu_model(input logic [31:0] a, input logic [31:0] b,
		input alu_op_e op, output logic ovf);
		longint s;
		ovf = 1'b0;
		case (op)
			ALU_ADD: s = longint'($signed(a)) + longint'($signed(b));
			ALU_SUB: s = longint'($signed(a)) - longint'($signed(b));
			default: s = 0;
		endcase
		if (op == ALU_ADD || op == ALU_SUB)
			ovf = (s > 64'sd2147483647) || (s < -64'sd2147483648);
		case (op)
			ALU_ADD, ALU_SUB: return s[31:0];
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			ALU_NOR: return ~(a | b);
			ALU_SLT: return {31'd0, $signed(a) < $signed(b)};
			ALU_SLTU: return {31'd0, a < b};
			ALU_LUI: return {b[15:0], 16'd0};
			default: return '0;
		endcase
	endfunction

	function automatic logic [31:0] shift_model(input logic [31:0] v, input logic [4:0] sh,
		input shift_op_e op);
		case (op)
			SH_SLL: return v << sh;
			SH_SRL: return v >> sh;
			default: return $signed(v) >>> sh;
		endcase
	endfunction

	// Updates HI and LO as the finished operation will leave them
	task automatic mdu_model(input instr_t t);
		logic        sgn;
		logic [63:0] prod;
		logic [31:0] aa;
		logic [31:0] bb;
		logic [31:0] q;
		logic [31:0] r;
		sgn = (t.mdu_op == MDU_MULT) || (t.mdu_op == MDU_DIV);
		case (t.mdu_op)
			MDU_MULT, MDU_MULTU: begin
				if (sgn)
					prod = {{32{t.a[31]}}, t.a} * {{32{t.b[31]}}, t.b};
				else
					prod = {32'd0, t.a} * {32'd0, t.b};
				{hi_m, lo_m} = prod;
				busy_left = MD_STEPS;
			end
			MDU_DIV, MDU_DIVU: begin
				aa = (sgn && t.a[31]) ? -t.a : t.a;
				bb = (sgn && t.b[31]) ? -t.b : t.b;
				q = (bb == 32'd0) ? 32'hffff_ffff : aa / bb;
				r = (bb == 32'd0) ? aa : aa % bb;
				lo_m = (sgn && (t.a[31] ^ t.b[31])) ? -q : q;
				hi_m = (sgn && t.a[31]) ? -r : r;
				busy_left = MD_STEPS;
			end
			MDU_MTHI: hi_m = t.a;
			MDU_MTLO: lo_m = t.a;
			default: ;
		endcase
	endtask

	task automatic retire_model(input instr_t t);
		entry_t      e;
		logic [31:0] bb;
		logic [31:0] alu_res;
		logic        ovf;
		bb = t.alu_b_sel ? t.imm : t.b;
		alu_res = alu_model(t.a, bb, t.alu_op, ovf);
		e.exc = t.of_ctrl && ovf;
		e.regwr = t.regwr && !e.exc;
		e.memtoreg = t.memtoreg && !e.exc;
		e.memwr = t.memwr && !e.exc;
		e.dmen = t.dmen && !e.exc;
		e.bytesel = t.bytesel;
		e.extsigned = t.extsigned;
		case (t.result_sel)
			RES_SHIFT: e.result = shift_model(t.b, t.alu_b_sel ? t.shamt : t.a[4:0], t.shift_op);
			RES_HI: e.result = hi_m;
			RES_LO: e.result = lo_m;
			RES_LINK: e.result = t.link;
			RES_CP0: e.result = t.cp0;
			default: e.result = alu_res;
		endcase
		e.store = t.b;
		e.regdst = t.regdst;
		e.pc = t.pc;
		expq.push_back(e);
		mdu_model(t);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_retired();
		entry_t e;
		if (mem_regwr_o || mem_dmen_o || exc_ov_o) begin
			if (expq.size() == 0) begin
				errors++;
				$display("Fail at %0d ns: an entry retired while none was expected", $time);
			end else begin
				e = expq.pop_front();
				check_value("pc", mem_pc_o, e.pc);
				check_value("exc_ov", 32'(exc_ov_o), 32'(e.exc));
				check_value("regwr", 32'(mem_regwr_o), 32'(e.regwr));
				check_value("memtoreg", 32'(mem_memtoreg_o), 32'(e.memtoreg));
				check_value("memwr", 32'(mem_memwr_o), 32'(e.memwr));
				check_value("dmen", 32'(mem_dmen_o), 32'(e.dmen));
				check_value("bytesel", 32'(mem_bytesel_o), 32'(e.bytesel));
				check_value("extsigned", 32'(mem_extsigned_o), 32'(e.extsigned));
				check_value("result", mem_result_o, e.result);
				check_value("store data", mem_store_data_o, e.store);
				check_value("regdst", 32'(mem_regdst_o), 32'(e.regdst));
			end
		end
	endtask

	always @(posedge clk) begin
		logic ex_stall;
		logic accept;
		logic [31:0] r;
		if (rst_n_i) begin
			if (mem_loaded)
				check_retired();
			ex_stall = (busy_left > 0) && ex_valid && (ex_m.result_sel == RES_HI ||
				ex_m.result_sel == RES_LO || ex_m.mdu_op != MDU_NONE);
			if (stall_o !== ex_stall) begin
				errors++;
				$display("Fail at %0d ns: stall_o is %b, expected %b", $time, stall_o, ex_stall);
			end
			accept = !hold_i && !ex_stall && !flush_i;
			mem_loaded = !hold_i;
			if (busy_left > 0)
				busy_left--;
			if (ex_valid && !hold_i && !ex_stall)
				retire_model(ex_m);
			if (flush_i) begin
				ex_valid = 1'b0;
			end else if (!hold_i && !ex_stall) begin
				ex_m = cur;
				ex_valid = cur_valid;
				if (cur_valid)
					issued++;
			end
			r = $random(seed);
			hold_i <= (issued < N_INSTR) && (r[2:0] == 3'd0);
			flush_i <= (issued < N_INSTR) && (r[7:3] == 5'd0);
			if (accept || flush_i) begin
				if (issued < N_INSTR) begin
					cur <= gen_instr();
					cur_valid <= 1'b1;
				end else begin
					cur <= '0;
					cur_valid <= 1'b0;
				end
			end
		end
	end

	initial begin
		int cyc;
		seed = 68;
		clk = 1'b0;
		rst_n_i = 1'b0;
		hold_i = 1'b0;
		flush_i = 1'b0;
		errors = 0;
		issued = 0;
		busy_left = 0;
		pc_next = 32'h0040_0000;
		hi_m = '0;
		lo_m = '0;
		ex_m = '0;
		ex_valid = 1'b0;
		mem_loaded = 1'b0;
		cur = gen_instr();
		cur_valid = 1'b1;
		repeat (2) @(posedge clk);
		rst_n_i <= 1'b1;
		for (cyc = 0; cyc < ISSUE_LIMIT && issued < N_INSTR; cyc++)
			@(posedge clk);
		if (issued < N_INSTR) begin
			errors++;
			$display("Timeout: only %0d of %0d instructions were issued", issued, N_INSTR);
		end
		for (cyc = 0; cyc < DRAIN_LIMIT && (expq.size() != 0 || ex_valid); cyc++)
			@(posedge clk);
		repeat (3) @(posedge clk);
		if (expq.size() != 0 || ex_valid) begin
			errors++;
			$display("Timeout: %0d expected entries never retired", expq.size());
		end
		$display("Issued %0d instructions, errors %0d", issued, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- filelist.f
logic/cpu_cfg_pkg.sv
logic/ex_ctrl_pkg.sv
logic/id_ex_register.sv
logic/ex_alu.sv
logic/ex_shifter.sv
logic/ex_muldiv.sv
logic/execute_unit.sv
bench/execute_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module execute_unit_tb \
	-o execute_unit_sim
./obj_dir/execute_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log || ! grep -q "Finished with no errors" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
